//--- cache/cache_array.sv
`timescale 1ns/100ps

module cache_array #(
    parameter int WORD_CAPACITY   = 8,
    parameter int WORDS_PER_BLOCK = 4,
    parameter int WAY_COUNT       = 2,
    localparam int WAY_W          = (WAY_COUNT > 1) ? $clog2(WAY_COUNT) : 1
) (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  cache_pkg::addr_t                      lookup_addr_i,
    input  logic                                  fill_en_i,
    input  logic [WAY_W-1:0]                      fill_way_i,
    input  cache_pkg::word_t [WORDS_PER_BLOCK-1:0] fill_block_i,
    output logic                                  hit_o,
    output cache_pkg::word_t                      rd_word_o
);
    import cache_pkg::*;

    localparam int SET_COUNT   = WORD_CAPACITY / WORDS_PER_BLOCK / WAY_COUNT;
    localparam int SET_BITS    = $clog2(SET_COUNT);
    localparam int SET_W       = (SET_BITS > 0) ? SET_BITS : 1;
    localparam int BYTE_OFF_W  = $clog2(WORD_W / 8);
    localparam int WIDX_W      = (WORDS_PER_BLOCK > 1) ? $clog2(WORDS_PER_BLOCK) : 1;
    localparam int BLOCK_OFF_W = $clog2(WORDS_PER_BLOCK) + BYTE_OFF_W;
    localparam int TAG_W       = ADDR_W - BLOCK_OFF_W - SET_BITS;

    logic [TAG_W-1:0]  tag;
    logic [SET_W-1:0]  set_index;
    logic [WIDX_W-1:0] word_index;

    logic [WAY_COUNT-1:0]                         way_hit;
    logic [WAY_COUNT-1:0]                         way_wr_en;
    word_t [WAY_COUNT-1:0][WORDS_PER_BLOCK-1:0]   way_block;

    // the address holds tag, set index, word index and byte offset from the top down
    assign tag        = lookup_addr_i[ADDR_W-1 -: TAG_W];
    assign set_index  = SET_W'((lookup_addr_i >> BLOCK_OFF_W) % SET_COUNT);
    assign word_index = WIDX_W'((lookup_addr_i >> BYTE_OFF_W) % WORDS_PER_BLOCK);

    for (genvar w = 0; w < WAY_COUNT; w++) begin : g_way
        assign way_wr_en[w] = fill_en_i && (fill_way_i == WAY_W'(w));

        cache_way #(
            .WORD_CAPACITY   (WORD_CAPACITY),
            .WORDS_PER_BLOCK (WORDS_PER_BLOCK),
            .WAY_COUNT       (WAY_COUNT)
        ) cache_way_inst (
            .clk_i       (clk_i),
            .rst_i       (rst_i),
            .tag_i       (tag),
            .set_index_i (set_index),
            .wr_en_i     (way_wr_en[w]),
            .wr_block_i  (fill_block_i),
            .hit_o       (way_hit[w]),
            .rd_block_o  (way_block[w])
        );
    end

    // at most one way hits and a miss reads as zero
    always_comb begin
        hit_o     = |way_hit;
        rd_word_o = '0;
        for (int w = 0; w < WAY_COUNT; w++) begin
            if (way_hit[w]) begin
                rd_word_o = way_block[w][word_index];
            end
        end
    end

endmodule

//--- cache/cache_way.sv
`timescale 1ns/100ps

module cache_way #(
    parameter int WORD_CAPACITY   = 8,
    parameter int WORDS_PER_BLOCK = 4,
    parameter int WAY_COUNT       = 2,
    localparam int SET_COUNT      = WORD_CAPACITY / WORDS_PER_BLOCK / WAY_COUNT,
    localparam int SET_BITS       = $clog2(SET_COUNT),
    localparam int SET_W          = (SET_BITS > 0) ? SET_BITS : 1,
    localparam int BLOCK_OFF_W    = $clog2(WORDS_PER_BLOCK) + $clog2(cache_pkg::WORD_W / 8),
    localparam int TAG_W          = cache_pkg::ADDR_W - BLOCK_OFF_W - SET_BITS
) (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic [TAG_W-1:0]                      tag_i,
    input  logic [SET_W-1:0]                      set_index_i,
    input  logic                                  wr_en_i,
    input  cache_pkg::word_t [WORDS_PER_BLOCK-1:0] wr_block_i,
    output logic                                  hit_o,
    output cache_pkg::word_t [WORDS_PER_BLOCK-1:0] rd_block_o
);
    import cache_pkg::*;

    // one entry per set
    logic [SET_COUNT-1:0]        valid_q;
    logic [TAG_W-1:0]            tag_q  [SET_COUNT];
    word_t [WORDS_PER_BLOCK-1:0] data_q [SET_COUNT];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[set_index_i] <= 1'b1;
        end
    end

    // tag and block storage is written as a whole block on refill
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_q[set_index_i]  <= tag_i;
            data_q[set_index_i] <= wr_block_i;
        end
    end

    // combinational read of the indexed entry
    assign hit_o      = valid_q[set_index_i] && (tag_q[set_index_i] == tag_i);
    assign rd_block_o = data_q[set_index_i];

endmodule

//--- cache_subsystem.f
common/cache_pkg.sv
cache/cache_way.sv
cache/cache_array.sv
logic/victim_select.sv
logic/refill_controller.sv
logic/cache_subsystem_top.sv
testbench/cache_props.sv
testbench/cache_tb.sv

//--- common/cache_pkg.sv
package cache_pkg;

    // byte address and data word widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;

    // load-port and refill sequencing of the controller
    typedef enum logic [2:0] {
        IDLE,
        REQUEST,
        COLLECT,
        FILL,
        RESPOND
    } refill_state_e;

endpackage

//--- logic/cache_subsystem_top.sv
`timescale 1ns/100ps

module cache_subsystem_top #(
    parameter int WORD_CAPACITY   = 8,
    parameter int WORDS_PER_BLOCK = 4,
    parameter int WAY_COUNT       = 2,
    parameter int REQ_CREDITS     = 2
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             cpu_req_valid_i,
    input  cache_pkg::addr_t cpu_addr_i,
    output logic             cpu_ready_o,
    output logic             cpu_rsp_valid_o,
    output cache_pkg::word_t cpu_rsp_word_o,
    output logic             cpu_rsp_hit_o,
    output logic             mem_req_valid_o,
    output cache_pkg::addr_t mem_req_addr_o,
    input  logic             mem_req_credit_i,
    input  logic             mem_rsp_valid_i,
    input  cache_pkg::word_t mem_rsp_word_i
);
    import cache_pkg::*;

    localparam int SET_COUNT   = WORD_CAPACITY / WORDS_PER_BLOCK / WAY_COUNT;
    localparam int SET_W       = (SET_COUNT > 1) ? $clog2(SET_COUNT) : 1;
    localparam int WAY_W       = (WAY_COUNT > 1) ? $clog2(WAY_COUNT) : 1;
    localparam int BLOCK_OFF_W = $clog2(WORDS_PER_BLOCK) + $clog2(WORD_W / 8);

    addr_t                       lookup_addr;
    logic                        lookup_hit;
    word_t                       lookup_word;
    logic                        fill_en;
    word_t [WORDS_PER_BLOCK-1:0] fill_block;
    addr_t                       fill_addr;
    logic [WAY_W-1:0]            victim_way;
    logic [SET_W-1:0]            victim_set;

    // the victim pointer follows the set being refilled
    assign victim_set = SET_W'((fill_addr >> BLOCK_OFF_W) % SET_COUNT);

    refill_controller #(
        .WORDS_PER_BLOCK (WORDS_PER_BLOCK),
        .REQ_CREDITS     (REQ_CREDITS)
    ) refill_controller_inst (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .cpu_req_valid_i  (cpu_req_valid_i),
        .cpu_addr_i       (cpu_addr_i),
        .cpu_ready_o      (cpu_ready_o),
        .cpu_rsp_valid_o  (cpu_rsp_valid_o),
        .cpu_rsp_word_o   (cpu_rsp_word_o),
        .cpu_rsp_hit_o    (cpu_rsp_hit_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_addr_o   (mem_req_addr_o),
        .mem_req_credit_i (mem_req_credit_i),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_word_i   (mem_rsp_word_i),
        .lookup_addr_o    (lookup_addr),
        .lookup_hit_i     (lookup_hit),
        .lookup_word_i    (lookup_word),
        .fill_en_o        (fill_en),
        .fill_block_o     (fill_block),
        .fill_addr_o      (fill_addr)
    );

    cache_array #(
        .WORD_CAPACITY   (WORD_CAPACITY),
        .WORDS_PER_BLOCK (WORDS_PER_BLOCK),
        .WAY_COUNT       (WAY_COUNT)
    ) cache_array_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .lookup_addr_i (lookup_addr),
        .fill_en_i     (fill_en),
        .fill_way_i    (victim_way),
        .fill_block_i  (fill_block),
        .hit_o         (lookup_hit),
        .rd_word_o     (lookup_word)
    );

    victim_select #(
        .WORD_CAPACITY   (WORD_CAPACITY),
        .WORDS_PER_BLOCK (WORDS_PER_BLOCK),
        .WAY_COUNT       (WAY_COUNT)
    ) victim_select_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .set_index_i  (victim_set),
        .advance_i    (fill_en),
        .victim_way_o (victim_way)
    );

endmodule

//--- logic/refill_controller.sv
`timescale 1ns/100ps

module refill_controller #(
    parameter int WORDS_PER_BLOCK = 4,
    parameter int REQ_CREDITS     = 2
) (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    // load port
    input  logic                                  cpu_req_valid_i,
    input  cache_pkg::addr_t                      cpu_addr_i,
    output logic                                  cpu_ready_o,
    output logic                                  cpu_rsp_valid_o,
    output cache_pkg::word_t                      cpu_rsp_word_o,
    output logic                                  cpu_rsp_hit_o,
    // memory request channel
    output logic                                  mem_req_valid_o,
    output cache_pkg::addr_t                      mem_req_addr_o,
    input  logic                                  mem_req_credit_i,
    // memory response channel
    input  logic                                  mem_rsp_valid_i,
    input  cache_pkg::word_t                      mem_rsp_word_i,
    // lookup
    output cache_pkg::addr_t                      lookup_addr_o,
    input  logic                                  lookup_hit_i,
    input  cache_pkg::word_t                      lookup_word_i,
    // fill
    output logic                                  fill_en_o,
    output cache_pkg::word_t [WORDS_PER_BLOCK-1:0] fill_block_o,
    output cache_pkg::addr_t                      fill_addr_o
);
    import cache_pkg::*;

    localparam int    BYTE_OFF_W = $clog2(WORD_W / 8);
    localparam int    WIDX_W     = (WORDS_PER_BLOCK > 1) ? $clog2(WORDS_PER_BLOCK) : 1;
    localparam int    CRED_W     = $clog2(REQ_CREDITS + 1);
    localparam addr_t BLOCK_MASK = addr_t'(WORDS_PER_BLOCK * (WORD_W / 8) - 1);

    refill_state_e state_q;
    refill_state_e state_d;

    addr_t                       miss_addr_q;
    logic [CRED_W-1:0]           credits_q;
    logic [WIDX_W-1:0]           word_cnt_q;
    logic [WIDX_W-1:0]           miss_widx;
    word_t [WORDS_PER_BLOCK-1:0] refill_buf_q;
    logic                        accept;
    logic                        last_word;

    assign cpu_ready_o = (state_q == IDLE);
    assign accept      = cpu_req_valid_i && cpu_ready_o;

    // while a miss is pending the array keeps looking at the missed address
    assign lookup_addr_o = (state_q == IDLE) ? cpu_addr_i : miss_addr_q;

    // one request per miss, only with a credit in hand
    assign mem_req_valid_o = (state_q == REQUEST) && (credits_q != '0);
    assign mem_req_addr_o  = miss_addr_q & ~BLOCK_MASK;

    assign fill_en_o    = (state_q == FILL);
    assign fill_block_o = refill_buf_q;
    assign fill_addr_o  = miss_addr_q;

    assign miss_widx = WIDX_W'((miss_addr_q >> BYTE_OFF_W) % WORDS_PER_BLOCK);
    assign last_word = mem_rsp_valid_i && (word_cnt_q == WIDX_W'(WORDS_PER_BLOCK - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept && !lookup_hit_i) begin
                    state_d = REQUEST;
                end
            end
            REQUEST: begin
                if (mem_req_valid_o) begin
                    state_d = COLLECT;
                end
            end
            COLLECT: begin
                if (last_word) begin
                    state_d = FILL;
                end
            end
            FILL:    state_d = RESPOND;
            RESPOND: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // spend on issue, refund on each returned credit pulse
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credits_q <= CRED_W'(REQ_CREDITS);
        end else begin
            credits_q <= credits_q - CRED_W'(mem_req_valid_o) + CRED_W'(mem_req_credit_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || state_q != COLLECT) begin
            word_cnt_q <= '0;
        end else if (mem_rsp_valid_i) begin
            word_cnt_q <= word_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            miss_addr_q <= cpu_addr_i;
        end
        // words arrive in ascending order
        if (state_q == COLLECT && mem_rsp_valid_i) begin
            refill_buf_q[word_cnt_q] <= mem_rsp_word_i;
        end
    end

    // hits answer one cycle after acceptance, misses answer in RESPOND
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cpu_rsp_valid_o <= 1'b0;
        end else begin
            cpu_rsp_valid_o <= (accept && lookup_hit_i) || (state_q == FILL);
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == FILL) begin
            cpu_rsp_word_o <= refill_buf_q[miss_widx];
            cpu_rsp_hit_o  <= 1'b0;
        end else begin
            cpu_rsp_word_o <= lookup_word_i;
            cpu_rsp_hit_o  <= 1'b1;
        end
    end

endmodule

//--- logic/victim_select.sv
`timescale 1ns/100ps

module victim_select #(
    parameter int WORD_CAPACITY   = 8,
    parameter int WORDS_PER_BLOCK = 4,
    parameter int WAY_COUNT       = 2,
    localparam int SET_COUNT      = WORD_CAPACITY / WORDS_PER_BLOCK / WAY_COUNT,
    localparam int SET_W          = (SET_COUNT > 1) ? $clog2(SET_COUNT) : 1,
    localparam int WAY_W          = (WAY_COUNT > 1) ? $clog2(WAY_COUNT) : 1
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic [SET_W-1:0] set_index_i,
    input  logic             advance_i,
    output logic [WAY_W-1:0] victim_way_o
);

    // round-robin pointer per set
    logic [WAY_W-1:0] ptr_q [SET_COUNT];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < SET_COUNT; s++) begin
                ptr_q[s] <= '0;
            end
        end else if (advance_i) begin
            // wrap after the last way
            if (ptr_q[set_index_i] == WAY_W'(WAY_COUNT - 1)) begin
                ptr_q[set_index_i] <= '0;
            end else begin
                ptr_q[set_index_i] <= ptr_q[set_index_i] + 1'b1;
            end
        end
    end

    assign victim_way_o = ptr_q[set_index_i];

endmodule

//--- testbench/cache_props.sv
`timescale 1ns/100ps

module cache_props #(
    parameter int REQ_CREDITS = 2
) (
    input logic clk_i,
    input logic rst_i,
    input logic req_valid_i,
    input logic ready_i,
    input logic rsp_valid_i,
    input logic rsp_hit_i,
    input logic mem_req_valid_i,
    input logic mem_req_credit_i
);

    // requests issued minus credits returned
    int outstanding;
    int failures = 0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(mem_req_valid_i) - int'(mem_req_credit_i);
        end
    end

    credit_bound: assert property (@(posedge clk_i) disable iff (rst_i)
        outstanding <= REQ_CREDITS)
        else begin
            $error("more memory requests outstanding than credits");
            failures++;
        end

    // a request may only go out with a credit in hand
    req_needs_credit: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_valid_i |-> outstanding < REQ_CREDITS)
        else begin
            $error("memory request issued without a credit");
            failures++;
        end

    // a hit answers in the next cycle, a miss drops ready instead
    hit_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        (req_valid_i && ready_i) |=> (rsp_valid_i && rsp_hit_i) || !ready_i)
        else begin
            $error("accepted load neither hit in one cycle nor stalled");
            failures++;
        end

    reset_quiet: assert property (@(posedge clk_i)
        $fell(rst_i) |-> !rsp_valid_i && !mem_req_valid_i && ready_i)
        else begin
            $error("outputs not quiet after reset");
            failures++;
        end

endmodule

bind cache_subsystem_top cache_props #(
    .REQ_CREDITS (REQ_CREDITS)
) cache_props_inst (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_valid_i      (cpu_req_valid_i),
    .ready_i          (cpu_ready_o),
    .rsp_valid_i      (cpu_rsp_valid_o),
    .rsp_hit_i        (cpu_rsp_hit_o),
    .mem_req_valid_i  (mem_req_valid_o),
    .mem_req_credit_i (mem_req_credit_i)
);

//--- testbench/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;
    import cache_pkg::*;

    localparam int    WORD_CAPACITY   = 8;
    localparam int    WORDS_PER_BLOCK = 4;
    localparam int    WAY_COUNT       = 2;
    localparam int    REQ_CREDITS     = 2;
    localparam int    TIMEOUT         = 200;
    localparam word_t DATA_KEY        = 32'hC0DE_0000;
    localparam addr_t BASE_ADDR       = 32'h0000_1000;
    // distance between blocks that land in the same set
    localparam int    SET_STRIDE      = WORD_CAPACITY / WAY_COUNT * (WORD_W / 8);
    localparam int    BLOCK_BYTES     = WORDS_PER_BLOCK * (WORD_W / 8);

    logic  clk_i            = 1'b0;
    logic  rst_i            = 1'b1;
    logic  cpu_req_valid_i  = 1'b0;
    addr_t cpu_addr_i       = '0;
    logic  mem_req_credit_i = 1'b0;
    logic  mem_rsp_valid_i  = 1'b0;
    word_t mem_rsp_word_i   = '0;
    logic  cpu_ready_o;
    logic  cpu_rsp_valid_o;
    word_t cpu_rsp_word_o;
    logic  cpu_rsp_hit_o;
    logic  mem_req_valid_o;
    addr_t mem_req_addr_o;

    logic  hold_credits = 1'b0;
    addr_t req_addr     = '0;
    int   credits_owed = 0;
    int   req_count    = 0;
    int   errors       = 0;
    int   checks       = 0;
    int   tests_run    = 0;
    int   errors_at_start = 0;

    cache_subsystem_top #(
        .WORD_CAPACITY   (WORD_CAPACITY),
        .WORDS_PER_BLOCK (WORDS_PER_BLOCK),
        .WAY_COUNT       (WAY_COUNT),
        .REQ_CREDITS     (REQ_CREDITS)
    ) cache_subsystem_top_inst (.*);

    initial begin
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        if (rst_i) begin
            credits_owed <= 0;
        end else begin
            credits_owed <= credits_owed + int'(mem_req_valid_o) - int'(mem_req_credit_i);
            req_count    <= req_count + int'(mem_req_valid_o);
            if (mem_req_valid_o) begin
                req_addr <= mem_req_addr_o;
            end
        end
    end

    // memory model with random credit and response delays
    initial begin
        void'($urandom(35));
        fork
            // credits go back unless they are being held
            forever begin : credit_return
                @(posedge clk_i);
                if (credits_owed != 0 && !hold_credits && !rst_i) begin
                    repeat ($urandom_range(3)) @(posedge clk_i);
                    mem_req_credit_i <= 1'b1;
                    @(posedge clk_i);
                    mem_req_credit_i <= 1'b0;
                end
            end
            // one block per request in ascending order
            forever begin : block_respond
                addr_t blk;
                @(posedge clk_i);
                if (mem_req_valid_o && !rst_i) begin
                    blk = mem_req_addr_o;
                    repeat ($urandom_range(4, 1)) @(posedge clk_i);
                    for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
                        mem_rsp_valid_i <= 1'b1;
                        mem_rsp_word_i  <= (blk + addr_t'(4 * i)) ^ DATA_KEY;
                        @(posedge clk_i);
                    end
                    mem_rsp_valid_i <= 1'b0;
                end
            end
        join
    end

    function automatic addr_t block_addr(input int k);
        return BASE_ADDR + addr_t'(k * SET_STRIDE);
    endfunction

    task automatic abort_run(input string why);
        $display("Error at %0t: %s", $time, why);
        $display("Verification failed");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("%0t: test %s finished with %0d errors", $time, name,
                 errors - errors_at_start);
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic apply_reset();
        rst_i <= 1'b1;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        @(posedge clk_i);
    endtask

    task automatic wait_credits_home();
        int cycles;
        cycles = 0;
        while (credits_owed != 0) begin
            @(posedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) abort_run("memory credits were never returned");
        end
    endtask

    task automatic load(input addr_t addr, input logic exp_hit);
        int cycles;
        int start_reqs;
        start_reqs = req_count;
        cpu_req_valid_i <= 1'b1;
        cpu_addr_i      <= addr;
        cycles = 0;
        do begin
            @(posedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) abort_run("load was never accepted");
        end while (!cpu_ready_o);
        cpu_req_valid_i <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) abort_run("no response to an accepted load");
        end while (!cpu_rsp_valid_o);
        check_value("cpu_rsp_hit_o", cpu_rsp_hit_o, exp_hit);
        check_value("cpu_rsp_word_o", cpu_rsp_word_o, addr ^ DATA_KEY);
        if (exp_hit) check_value("cpu_rsp_valid_o latency", cycles, 1);
        check_value("mem_req_valid_o count", req_count - start_reqs, exp_hit ? 0 : 1);
        if (!exp_hit) begin
            check_value("mem_req_addr_o", req_addr, addr - addr % BLOCK_BYTES);
        end
    endtask

    // loads words 1 and up of a cached block, one per cycle
    task automatic burst_block(input addr_t base);
        int start_reqs;
        start_reqs = req_count;
        cpu_req_valid_i <= 1'b1;
        cpu_addr_i      <= base + 4;
        for (int i = 1; i <= WORDS_PER_BLOCK; i++) begin
            @(posedge clk_i);
            if (i < WORDS_PER_BLOCK) check_value("cpu_ready_o", cpu_ready_o, 1);
            if (i > 1) begin
                check_value("cpu_rsp_valid_o", cpu_rsp_valid_o, 1);
                check_value("cpu_rsp_hit_o", cpu_rsp_hit_o, 1);
                check_value("cpu_rsp_word_o", cpu_rsp_word_o,
                            (base + addr_t'(4 * (i - 1))) ^ DATA_KEY);
            end
            if (i + 1 < WORDS_PER_BLOCK) begin
                cpu_addr_i <= base + addr_t'(4 * (i + 1));
            end else begin
                cpu_req_valid_i <= 1'b0;
            end
        end
        check_value("mem_req_valid_o count", req_count - start_reqs, 0);
    endtask

    initial begin
        apply_reset();

        load(block_addr(0), 1'b0);
        end_test("cold miss");
        load(block_addr(0), 1'b1);
        end_test("repeat hit");
        burst_block(block_addr(0));
        end_test("back-to-back hits");

        // WAY_COUNT more blocks in the same set push the first one out
        for (int k = 1; k <= WAY_COUNT; k++) begin
            load(block_addr(k), 1'b0);
        end
        load(block_addr(0) + 8, 1'b0);
        load(block_addr(WAY_COUNT), 1'b1);
        end_test("round-robin eviction");

        wait_credits_home();
        hold_credits <= 1'b1;
        load(block_addr(10), 1'b0);
        load(block_addr(11), 1'b0);
        fork
            load(block_addr(12), 1'b0);
            begin
                repeat (8) begin
                    @(posedge clk_i);
                    check_value("mem_req_valid_o", mem_req_valid_o, 0);
                end
                hold_credits <= 1'b0;
            end
        join
        end_test("credit withholding");

        wait_credits_home();
        apply_reset();
        load(block_addr(12), 1'b0);
        end_test("miss after reset");

        errors = errors + cache_subsystem_top_inst.cache_props_inst.failures;
        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
